// ==== src.f ====
rtl/rvPkg.sv
rtl/exePkg.sv
rtl/alu.sv
rtl/branchUnit.sv
rtl/mulDiv.sv
rtl/dataMem.sv
rtl/exeStage.sv
dv/clockGen.sv
dv/exeTb.sv

// ==== Makefile ====
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= exeTb
FILELIST  ?= src.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for a failure"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/exeTb.sv ====
`timescale 1ns/100ps

module exeTb;
	import rvPkg::*;
	import exePkg::*;

	typedef struct {
		logic valid, we, isBranch, isJal, isJalr;
		regIdxT rd;
		wordT opA, opB, imm, pc, storeData;
		aluFnT aluFn;
		mulDivOpT mulDivOp;
		memOpT memOp;
		brCondT brCond;
		wbSelT wbSel;
	} instT;

	typedef struct {
		logic v, we, mis;
		regIdxT rd;
		wordT data;
	} expT;

	localparam int totalSteps = 8 + 300 + 200 + 150 + 208 + 100 + 6 * 3;
	localparam aluFnT aluFns [10] = '{aluAdd, aluSub, aluSll, aluSlt, aluSltu,
		aluXor, aluSrl, aluSra, aluOr, aluAnd};
	localparam memOpT memOps [8] = '{memLb, memLh, memLw, memLbu, memLhu, memSb, memSh, memSw};
	localparam brCondT brConds [6] = '{brEq, brNe, brLt, brGe, brLtu, brGeu};

	logic clk, nrst;
	logic valid, we, isBranch, isJal, isJalr;
	regIdxT rd;
	wordT opA, opB, imm, pc, storeData;
	aluFnT aluFn;
	mulDivOpT mulDivOp;
	memOpT memOp;
	brCondT brCond;
	wbSelT wbSel;
	logic wbValid, wbWe, memMisaligned, redirect;
	regIdxT wbRd;
	wordT wbData, target;

	int seed = 38128;
	int errCount = 0;
	int checkCount = 0;
	int testCount = 0;
	instT ins;
	expT pipe [$];
	logic expRedirect = 1'b0;
	wordT expTarget;
	logic [7:0] shadowMem [256]; // byte mirror of the 64 word memory

	clockGen clkGen (.clk(clk), .nrst(nrst));

	exeStage #(.memWords(64)) uut (.*);

	function automatic wordT rnd();
		rnd = $random(seed);
	endfunction

	task automatic checkVal(string name, wordT exp, wordT act);
		checkCount++;
		valueOk: assert (act === exp)
		else
		begin
			$display("** Error: %s expected %h actual %h", name, exp, act);
			errCount++;
		end
	endtask

	function automatic wordT aluModel(aluFnT fn, wordT a, wordT b);
		case (fn)
			aluAdd:  return a + b;
			aluSub:  return a - b;
			aluSll:  return a << b[4:0];
			aluSlt:  return (int'(a) < int'(b)) ? 1 : 0;
			aluSltu: return (a < b) ? 1 : 0;
			aluXor:  return a ^ b;
			aluSrl:  return a >> b[4:0];
			aluSra:  return int'(a) >>> b[4:0];
			aluOr:   return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic wordT mdModel(mulDivOpT op, wordT a, wordT b);
		longint sa, sb, ub;
		logic [63:0] p;
		sa = int'(a);
		sb = int'(b);
		ub = {32'b0, b};
		case (op)
			mdMul:    p = sa * sb;
			mdMulh:   p = sa * sb;
			mdMulhsu: p = sa * ub;
			mdMulhu:  p = {32'b0, a} * ub;
			default:  p = '0;
		endcase
		if (op == mdMul)
			return p[31:0];
		if (op <= mdMulhu)
			return p[63:32];
		if (b == 0)
			return (op == mdDiv || op == mdDivu) ? 32'hffff_ffff : a;
		if (a == 32'h8000_0000 && b == 32'hffff_ffff && (op == mdDiv || op == mdRem))
			return (op == mdDiv) ? a : 32'h0;
		case (op)
			mdDiv:   return int'(a) / int'(b); // truncates toward zero
			mdDivu:  return a / b;
			mdRem:   return int'(a) % int'(b);
			default: return a % b;
		endcase
	endfunction

	// memory side of the model with the byte mirror updated on stores
	task automatic memModel(instT i, inout expT e);
		wordT addr;
		logic [1:0] w;
		addr = (i.opA + i.imm) & 32'hff;
		w = i.memOp[1:0];
		e.mis = (w == widthHalf && addr[0]) || (w == widthWord && addr[1:0] != 0);
		e.data = '0;
		if (e.mis)
			e.we = 1'b0;
		else if (i.memOp[3])
		begin
			for (int k = 0; k < (1 << w); k++)
				shadowMem[(addr + k) & 255] = i.storeData[8*k +: 8];
		end
		else
		begin
			for (int k = 0; k < (1 << w); k++)
				e.data[8*k +: 8] = shadowMem[(addr + k) & 255];
			if (!i.memOp[2] && w == widthByte)
				e.data = {{24{e.data[7]}}, e.data[7:0]};
			if (!i.memOp[2] && w == widthHalf)
				e.data = {{16{e.data[15]}}, e.data[15:0]};
		end
	endtask

	task automatic bubble();
		ins = '{valid: 0, we: 0, isBranch: 0, isJal: 0, isJalr: 0, rd: 0, opA: 0, opB: 0,
			imm: 0, pc: 0, storeData: 0, aluFn: aluAdd, mulDivOp: mdMul, memOp: memNone,
			brCond: brEq, wbSel: wbAlu};
	endtask

	// checks what is due and issues ins with its expected result
	task automatic step();
		expT e;
		logic condHolds;
		@(posedge clk);
		if (pipe.size() == 3)
		begin
			e = pipe.pop_front();
			checkVal("wbValid", e.v, wbValid);
			checkVal("wbWe", e.we, wbWe);
			checkVal("memMisaligned", e.mis, memMisaligned);
			if (e.v)
				checkVal("wbRd", e.rd, wbRd);
			if (e.we)
				checkVal("wbData", e.data, wbData);
		end
		checkVal("redirect", expRedirect, redirect);
		if (expRedirect)
			checkVal("target", expTarget, target);
		valid <= ins.valid;
		we <= ins.we;
		isBranch <= ins.isBranch;
		isJal <= ins.isJal;
		isJalr <= ins.isJalr;
		rd <= ins.rd;
		opA <= ins.opA;
		opB <= ins.opB;
		imm <= ins.imm;
		pc <= ins.pc;
		storeData <= ins.storeData;
		aluFn <= ins.aluFn;
		mulDivOp <= ins.mulDivOp;
		memOp <= ins.memOp;
		brCond <= ins.brCond;
		wbSel <= ins.wbSel;
		e = '{v: ins.valid, we: ins.valid & ins.we, mis: 0, rd: ins.rd, data: 0};
		case (ins.wbSel)
			wbAlu:    e.data = aluModel(ins.aluFn, ins.opA, ins.opB);
			wbLink:   e.data = ins.pc + 4;
			wbMulDiv: e.data = mdModel(ins.mulDivOp, ins.opA, ins.opB);
			wbLui:    e.data = ins.imm;
			wbAuipc:  e.data = ins.pc + ins.imm;
			default:  e.data = '0;
		endcase
		if (ins.valid && ins.memOp != memNone)
			memModel(ins, e);
		case (ins.brCond)
			brEq:    condHolds = ins.opA == ins.opB;
			brNe:    condHolds = ins.opA != ins.opB;
			brLt:    condHolds = int'(ins.opA) < int'(ins.opB);
			brGe:    condHolds = int'(ins.opA) >= int'(ins.opB);
			brLtu:   condHolds = ins.opA < ins.opB;
			default: condHolds = ins.opA >= ins.opB;
		endcase
		expRedirect = ins.valid & (ins.isJal | ins.isJalr | (ins.isBranch & condHolds));
		expTarget = ins.isJalr ? ((ins.opA + ins.imm) & ~32'h1) : ins.pc + ins.imm;
		pipe.push_back(e);
	endtask

	task automatic endTest(string name, int errBefore);
		repeat (3)
		begin
			bubble();
			step();
		end
		testCount++;
		$display("test %s done, %0d errors", name, errCount - errBefore);
	endtask

	task automatic aluOp();
		bubble();
		ins.valid = 1;
		ins.we = 1;
		ins.rd = rnd();
		ins.opA = rnd();
		ins.opB = rnd();
	endtask

	initial
	begin
		int errBefore;
		bubble();
		{valid, we, isBranch, isJal, isJalr, rd, opA, opB, imm, pc, storeData} = '0;
		aluFn = aluAdd;
		mulDivOp = mdMul;
		memOp = memNone;
		brCond = brEq;
		wbSel = wbAlu;
		for (int k = 0; k < 256; k++)
			shadowMem[k] = 8'h0;

		errBefore = errCount;
		while (!nrst)
		begin
			@(posedge clk);
			checkVal("wbValid", 0, wbValid);
			checkVal("wbWe", 0, wbWe);
			checkVal("memMisaligned", 0, memMisaligned);
			checkVal("redirect", 0, redirect);
		end
		repeat (8) step(); // idle cycles
		endTest("reset", errBefore);

		errBefore = errCount;
		repeat (300)
		begin
			aluOp();
			ins.aluFn = aluFns[(rnd() & 32'h7fff_ffff) % 10];
			step();
		end
		endTest("alu", errBefore);

		errBefore = errCount;
		for (int n = 0; n < 200; n++)
		begin
			aluOp();
			ins.wbSel = wbMulDiv;
			ins.mulDivOp = rnd();
			if (n % 8 == 3)
				ins.opB = 0;
			if (n % 8 == 6)
			begin
				ins.opA = 32'h8000_0000;
				ins.opB = 32'hffff_ffff;
			end
			step();
		end
		endTest("muldiv", errBefore);

		errBefore = errCount;
		repeat (150)
		begin
			aluOp();
			ins.pc = rnd() & ~32'h3;
			ins.imm = rnd();
			ins.wbSel = wbLink;
			ins.brCond = brConds[(rnd() & 32'h7fff_ffff) % 6];
			case (rnd() & 3)
				0: ins.isJal = 1;
				1: ins.isJalr = 1;
				default:
				begin
					ins.isBranch = 1;
					ins.we = 0;
					if (rnd() & 1)
						ins.opB = ins.opA; // equal operands now and then
				end
			endcase
			step();
		end
		endTest("branch", errBefore);

		errBefore = errCount;
		for (int n = 0; n < 208; n++)
		begin
			aluOp();
			ins.imm = rnd() & 32'hf;
			ins.storeData = rnd();
			if (n < 8)
			begin
				ins.opA = 4 * n - ins.imm; // fill the window with words first
				ins.memOp = memSw;
			end
			else
			begin
				ins.opA = (rnd() & 32'h1f) - ins.imm;
				ins.memOp = memOps[rnd() & 7];
			end
			ins.we = !ins.memOp[3];
			ins.wbSel = wbMem;
			step();
		end
		endTest("loadstore", errBefore);

		errBefore = errCount;
		repeat (100)
		begin
			aluOp();
			ins.pc = rnd();
			ins.imm = rnd() & 32'hffff_f000;
			ins.wbSel = (rnd() & 1) ? wbLui : wbAuipc;
			step();
		end
		endTest("luiauipc", errBefore);

		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
		if (errCount == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial
	begin
		#((totalSteps + 10 + 100) * 4);
		$display("timeout, the tests did not finish in time");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== dv/clockGen.sv ====
`timescale 1ns/100ps

module clockGen
#(
	parameter int resetCycles = 10
)
(
	output logic clk,
	output logic nrst
);
	initial
	begin
		clk = 1'b0;
		nrst = 1'b0;
		repeat (resetCycles) @(posedge clk);
		nrst <= 1'b1; // released just after the edge
	end

	always #2 clk = ~clk; // 4 ns period

endmodule

// ==== rtl/exeStage.sv ====
`timescale 1ns/100ps

module exeStage
#(
	parameter int memWords = 256
)
(
	input logic clk,
	input logic nrst,
	input logic valid,
	input logic we,
	input logic isBranch,
	input logic isJal,
	input logic isJalr,
	input rvPkg::regIdxT rd,
	input rvPkg::wordT opA,
	input rvPkg::wordT opB,
	input rvPkg::wordT imm,
	input rvPkg::wordT pc,
	input rvPkg::wordT storeData,
	input exePkg::aluFnT aluFn,
	input exePkg::mulDivOpT mulDivOp,
	input exePkg::memOpT memOp,
	input rvPkg::brCondT brCond,
	input exePkg::wbSelT wbSel,
	output logic wbValid,
	output logic wbWe,
	output logic memMisaligned,
	output logic redirect,
	output rvPkg::regIdxT wbRd,
	output rvPkg::wordT wbData,
	output rvPkg::wordT target
);
	import rvPkg::*;
	import exePkg::*;

	// stage 5
	logic valid5, we5;
	memOpT memOp5;
	regIdxT rd5;
	wordT opA5, opB5, imm5, pc5, storeData5;
	aluFnT aluFn5;
	mulDivOpT mulDivOp5;
	wbSelT wbSel5;
	wordT aluRes5, mulDivRes5, memAddr5;

	// stage 6
	logic valid6, we6;
	regIdxT rd6;
	wbSelT wbSel6;
	wordT aluRes6, mulDivRes6, imm6, auipc6, link6, loadData6;

	logic taken;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			valid5 <= 1'b0;
			we5 <= 1'b0;
			memOp5 <= memNone;
			valid6 <= 1'b0;
			we6 <= 1'b0;
		end
		else
		begin
			valid5 <= valid;
			we5 <= valid & we;
			memOp5 <= valid ? memOp : memNone; // bubbles never touch memory
			valid6 <= valid5;
			we6 <= we5;
		end
	end

	always_ff @(posedge clk)
	begin
		rd5 <= rd;
		opA5 <= opA;
		opB5 <= opB;
		imm5 <= imm;
		pc5 <= pc;
		storeData5 <= storeData;
		aluFn5 <= aluFn;
		mulDivOp5 <= mulDivOp;
		wbSel5 <= wbSel;

		rd6 <= rd5;
		wbSel6 <= wbSel5;
		aluRes6 <= aluRes5;
		mulDivRes6 <= mulDivRes5;
		imm6 <= imm5;
		auipc6 <= pc5 + imm5;
		link6 <= pc5 + instBytes;
	end

	alu exeAlu (.fn(aluFn5), .a(opA5), .b(opB5), .result(aluRes5));

	mulDiv exeMulDiv (.op(mulDivOp5), .a(opA5), .b(opB5), .result(mulDivRes5));

	// resolved from the issue inputs rather than stage 5
	branchUnit exeBranch (
		.isBranch(isBranch),
		.isJal(isJal),
		.isJalr(isJalr),
		.cond(brCond),
		.a(opA),
		.b(opB),
		.pc(pc),
		.imm(imm),
		.taken(taken),
		.target(target)
	);

	assign memAddr5 = opA5 + imm5;

	dataMem #(.memWords(memWords)) exeMem (
		.clk(clk),
		.nrst(nrst),
		.op(memOp5),
		.addr(memAddr5),
		.storeData(storeData5),
		.loadData(loadData6),
		.misaligned(memMisaligned)
	);

	assign redirect = valid & taken;

	assign wbValid = valid6;
	assign wbWe = we6 & ~memMisaligned; // a faulting access writes nothing back
	assign wbRd = rd6;

	always_comb
	begin
		case (wbSel6)
			wbAlu:    wbData = aluRes6;
			wbLink:   wbData = link6;
			wbMulDiv: wbData = mulDivRes6;
			wbLui:    wbData = imm6;
			wbMem:    wbData = loadData6;
			wbAuipc:  wbData = auipc6;
			default:  wbData = '0;
		endcase
	end

	wbWeHasValid: assert property (@(posedge clk) disable iff (!nrst) wbWe |-> wbValid)
		else $error("wbWe without wbValid");

	// only a valid control transfer may redirect
	redirectHasValid: assert property (@(posedge clk) disable iff (!nrst)
		redirect |-> valid && (isBranch || isJal || isJalr))
		else $error("redirect on an idle cycle or a non-control instruction");

	wbRdKnown: assert property (@(posedge clk) disable iff (!nrst)
		wbValid |-> !$isunknown(wbRd))
		else $error("wbRd unknown at write-back");

endmodule

// ==== rtl/dataMem.sv ====
`timescale 1ns/100ps

module dataMem
#(
	parameter int memWords = 256
)
(
	input logic clk,
	input logic nrst,
	input exePkg::memOpT op,
	input rvPkg::wordT addr,
	input rvPkg::wordT storeData,
	output rvPkg::wordT loadData,
	output logic misaligned
);
	import rvPkg::*;
	import exePkg::*;

	localparam int idxBits = $clog2(memWords);

	wordT mem [memWords];

	logic [idxBits-1:0] wordIdx;
	logic [1:0] byteOff;
	memWidthT width;
	logic isAccess, isStore, isLoad;
	logic badAlign;
	logic memWrite;
	logic [3:0] byteEn;
	wordT laneData;
	wordT rdWord, rdShift, rdExt;

	// byte address wraps at the memory size
	assign wordIdx = addr[idxBits+1:2];
	assign byteOff = addr[1:0];

	assign width = op[1:0];
	assign isAccess = width != widthNone;
	assign isStore = isAccess & op[3];
	assign isLoad = isAccess & ~op[3];

	always_comb
	begin
		case (width)
			widthHalf: badAlign = byteOff[0];
			widthWord: badAlign = byteOff != 2'b00;
			default:   badAlign = 1'b0;
		endcase
	end

	// store data replicated so every lane sees its byte
	always_comb
	begin
		case (width)
			widthByte:
			begin
				byteEn = 4'b0001 << byteOff;
				laneData = {4{storeData[7:0]}};
			end
			widthHalf:
			begin
				byteEn = 4'b0011 << byteOff;
				laneData = {2{storeData[15:0]}};
			end
			default:
			begin
				byteEn = 4'b1111;
				laneData = storeData;
			end
		endcase
	end

	assign memWrite = isStore & ~badAlign;

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 4; i++)
		begin
			if (memWrite && byteEn[i])
				mem[wordIdx][8*i +: 8] <= laneData[8*i +: 8];
		end
	end

	// read side still in stage 5
	assign rdWord = mem[wordIdx];
	assign rdShift = rdWord >> {byteOff, 3'b000};

	always_comb
	begin
		case (width)
			widthByte: rdExt = {{24{rdShift[7] & ~op[2]}}, rdShift[7:0]};
			widthHalf: rdExt = {{16{rdShift[15] & ~op[2]}}, rdShift[15:0]};
			default:   rdExt = rdWord;
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			loadData <= '0;
			misaligned <= 1'b0;
		end
		else
		begin
			loadData <= (isLoad && !badAlign) ? rdExt : '0;
			misaligned <= isAccess & badAlign;
		end
	end

	// a misaligned store leaves its word as it was
	noWriteWhenMisaligned: assert property (@(posedge clk) disable iff (!nrst)
		isStore && badAlign |=> mem[$past(wordIdx)] === $past(rdWord))
		else $error("misaligned store changed the memory");

endmodule

// ==== rtl/mulDiv.sv ====
`timescale 1ns/100ps

module mulDiv
(
	input exePkg::mulDivOpT op,
	input rvPkg::wordT a,
	input rvPkg::wordT b,
	output rvPkg::wordT result
);
	import exePkg::*;
	import rvPkg::*;

	logic [63:0] aExt, bExt;
	logic [63:0] prodSs, prodSu, prodUu;
	logic divZero, overflow;
	wordT divisor, aMag, bMag, quotMag, remMag;
	wordT quotS, remS, quotU, remU;

	// low 64 bits of a product of sign extended words are exact
	assign aExt = {{32{a[31]}}, a};
	assign bExt = {{32{b[31]}}, b};
	assign prodSs = aExt * bExt;
	assign prodSu = aExt * {32'b0, b};
	assign prodUu = {32'b0, a} * {32'b0, b};

	assign divZero = b == '0;
	assign overflow = (a == wordMinSigned) && (b == '1);
	assign divisor = divZero ? 32'd1 : b; // keeps the dividers defined

	// signed divide done on magnitudes, signs fixed afterwards
	assign aMag = a[31] ? -a : a;
	assign bMag = divisor[31] ? -divisor : divisor;
	assign quotMag = aMag / bMag;
	assign remMag = aMag % bMag;
	assign quotS = (a[31] ^ divisor[31]) ? -quotMag : quotMag;
	assign remS = a[31] ? -remMag : remMag; // remainder takes the dividend's sign

	assign quotU = a / divisor;
	assign remU = a % divisor;

	always_comb
	begin
		case (op)
			mdMul:    result = prodSs[31:0];
			mdMulh:   result = prodSs[63:32];
			mdMulhsu: result = prodSu[63:32];
			mdMulhu:  result = prodUu[63:32];
			mdDiv:    result = divZero ? '1 : (overflow ? a : quotS);
			mdDivu:   result = divZero ? '1 : quotU;
			mdRem:    result = divZero ? a : (overflow ? '0 : remS);
			default:  result = divZero ? a : remU; // remu
		endcase
	end

	always_comb
	begin
		if (!$isunknown({op, a, b}))
			resultKnown: assert final (!$isunknown(result))
				else $error("mulDiv result unknown, op %0d", op);
	end

endmodule

// ==== rtl/branchUnit.sv ====
`timescale 1ns/100ps

module branchUnit
(
	input logic isBranch,
	input logic isJal,
	input logic isJalr,
	input rvPkg::brCondT cond,
	input rvPkg::wordT a,
	input rvPkg::wordT b,
	input rvPkg::wordT pc,
	input rvPkg::wordT imm,
	output logic taken,
	output rvPkg::wordT target
);
	import rvPkg::*;

	logic condHolds;
	wordT jalrSum;

	always_comb
	begin
		case (cond)
			brEq:    condHolds = a == b;
			brNe:    condHolds = a != b;
			brLt:    condHolds = $signed(a) < $signed(b);
			brGe:    condHolds = $signed(a) >= $signed(b);
			brLtu:   condHolds = a < b;
			brGeu:   condHolds = a >= b;
			default: condHolds = 1'b0;
		endcase
	end

	assign jalrSum = a + imm;

	// jalr drops bit 0 of the sum, the others are pc relative
	assign target = isJalr ? {jalrSum[31:1], 1'b0} : pc + imm;

	assign taken = isJal | isJalr | (isBranch & condHolds);

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/100ps

module alu
(
	input exePkg::aluFnT fn,
	input rvPkg::wordT a,
	input rvPkg::wordT b,
	output rvPkg::wordT result
);
	import exePkg::*;

	logic [4:0] shamt;
	logic lessSigned;
	logic lessUnsigned;

	assign shamt = b[4:0]; // only the low five bits count on RV32

	assign lessSigned = $signed(a) < $signed(b);
	assign lessUnsigned = a < b;

	always_comb
	begin
		case (fn)
			aluAdd:
				result = a + b;
			aluSub:
				result = a - b;
			aluSll:
				result = a << shamt;
			aluSlt:
				result = {31'b0, lessSigned};
			aluSltu:
				result = {31'b0, lessUnsigned};
			aluXor:
				result = a ^ b;
			aluSrl:
				result = a >> shamt;
			aluSra:
				result = $signed(a) >>> shamt; // sign bit fills from the left
			aluOr:
				result = a | b;
			aluAnd:
				result = a & b;
			default:
				result = '0; // unused codes
		endcase
	end

endmodule

// ==== rtl/exePkg.sv ====
package exePkg;

	// alu function, laid out as {funct7[5], funct3}
	typedef logic [3:0] aluFnT;

	localparam aluFnT aluAdd  = 4'b0000;
	localparam aluFnT aluSub  = 4'b1000;
	localparam aluFnT aluSll  = 4'b0001;
	localparam aluFnT aluSlt  = 4'b0010;
	localparam aluFnT aluSltu = 4'b0011;
	localparam aluFnT aluXor  = 4'b0100;
	localparam aluFnT aluSrl  = 4'b0101;
	localparam aluFnT aluSra  = 4'b1101;
	localparam aluFnT aluOr   = 4'b0110;
	localparam aluFnT aluAnd  = 4'b0111;

	// RV32M funct3 order
	typedef logic [2:0] mulDivOpT;

	localparam mulDivOpT mdMul    = 3'd0;
	localparam mulDivOpT mdMulh   = 3'd1;
	localparam mulDivOpT mdMulhsu = 3'd2;
	localparam mulDivOpT mdMulhu  = 3'd3;
	localparam mulDivOpT mdDiv    = 3'd4;
	localparam mulDivOpT mdDivu   = 3'd5;
	localparam mulDivOpT mdRem    = 3'd6;
	localparam mulDivOpT mdRemu   = 3'd7;

	// {store, unsigned, width}
	typedef logic [3:0] memOpT;

	localparam memOpT memNone = {1'b0, 1'b0, rvPkg::widthNone};
	localparam memOpT memLb   = {1'b0, 1'b0, rvPkg::widthByte};
	localparam memOpT memLh   = {1'b0, 1'b0, rvPkg::widthHalf};
	localparam memOpT memLw   = {1'b0, 1'b0, rvPkg::widthWord};
	localparam memOpT memLbu  = {1'b0, 1'b1, rvPkg::widthByte};
	localparam memOpT memLhu  = {1'b0, 1'b1, rvPkg::widthHalf};
	localparam memOpT memSb   = {1'b1, 1'b0, rvPkg::widthByte};
	localparam memOpT memSh   = {1'b1, 1'b0, rvPkg::widthHalf};
	localparam memOpT memSw   = {1'b1, 1'b0, rvPkg::widthWord};

	typedef logic [2:0] wbSelT;

	localparam wbSelT wbAlu    = 3'd0;
	localparam wbSelT wbLink   = 3'd1; // pc+4
	localparam wbSelT wbMulDiv = 3'd2;
	localparam wbSelT wbLui    = 3'd3; // immediate as is
	localparam wbSelT wbMem    = 3'd4;
	localparam wbSelT wbAuipc  = 3'd5; // pc+imm

endpackage

// ==== rtl/rvPkg.sv ====
package rvPkg;

	// data, address and pc all share one width
	typedef logic [31:0] wordT;

	typedef logic [4:0] regIdxT;

	// branch condition, same codes as the funct3 field of B-type
	typedef logic [2:0] brCondT;

	localparam brCondT brEq  = 3'b000;
	localparam brCondT brNe  = 3'b001;
	localparam brCondT brLt  = 3'b100;
	localparam brCondT brGe  = 3'b101;
	localparam brCondT brLtu = 3'b110;
	localparam brCondT brGeu = 3'b111;

	// load/store access width
	typedef logic [1:0] memWidthT;

	localparam memWidthT widthByte = 2'b00;
	localparam memWidthT widthHalf = 2'b01;
	localparam memWidthT widthWord = 2'b10;

	// 2'b11 is left free; the memory op encoding uses it for "no access"
	localparam memWidthT widthNone = 2'b11;

	// byte offset of the link address
	localparam wordT instBytes = 32'd4;

	// most negative signed word, the one value that overflows on division
	localparam wordT wordMinSigned = 32'h8000_0000;

endpackage
